// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = fm_operator_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
source/fm_op_pkg.sv
source/phase_unit.sv
source/logsin_rom.sv
source/op_atten.sv
source/op_exp.sv
source/fm_operator.sv
tests/logsin_rom_properties.sv
tests/fm_operator_tb.sv

// File: source/fm_op_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM operator package: widths, scalar types and per-stage pipeline structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fm_op_pkg;

  localparam int phase_width     = 20;
  // Top accumulator bits used for the sine lookup
  localparam int phase_top_width = 10;
  localparam int addr_width      = 8;
  localparam int table_depth     = 1 << addr_width;
  localparam int logsin_width    = 12;
  localparam int env_width       = 10;
  // Envelope is scaled by four before the log-domain add
  localparam int env_shift       = 2;
  localparam int atten_width     = 12;
  localparam int mant_width      = 11;
  localparam int sample_width    = 12;
  // Log-domain steps per factor of two
  localparam int log_steps       = 256;
  localparam real pi             = 3.14159265358979;

  typedef logic [phase_width-1:0]         phase_t;
  typedef logic [addr_width-1:0]          rom_addr_t;
  typedef logic [logsin_width-1:0]        logsin_t;
  typedef logic [env_width-1:0]           env_t;
  typedef logic [atten_width-1:0]         atten_t;
  typedef logic [mant_width-1:0]          mant_t;
  typedef logic signed [sample_width-1:0] sample_t;

  localparam atten_t atten_max = '1;

  typedef struct packed {
    rom_addr_t addr;
    logic      sign;
  } phase_stage_t;

  typedef struct packed {
    logsin_t logsin;
    logic    sign;
  } log_stage_t;

  typedef struct packed {
    atten_t atten;
    logic   sign;
  } atten_stage_t;

endpackage

// File: source/fm_operator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM operator top: phase, log-sine, attenuation and exponent stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fm_operator (
  input  logic               clk,
  input  logic               rst,
  input  logic               clk_en,
  input  fm_op_pkg::phase_t  phase_inc,
  input  fm_op_pkg::env_t    env_atten,
  output fm_op_pkg::sample_t sample
);
  import fm_op_pkg::*;

  // One struct per stage boundary with the sign beside the data
  phase_stage_t phase_stage;
  log_stage_t   log_stage;
  atten_stage_t atten_stage;

  phase_unit u_phase (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .phase_inc (phase_inc),
    .stage     (phase_stage)
  );

  logsin_rom u_logsin (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .in_stage  (phase_stage),
    .out_stage (log_stage)
  );

  // Envelope is sampled here two strobes after the phase update
  op_atten u_atten (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .in_stage  (log_stage),
    .env_atten (env_atten),
    .out_stage (atten_stage)
  );

  op_exp u_exp (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .in_stage (atten_stage),
    .sample   (sample)
  );

endmodule

// File: source/logsin_rom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered quarter-wave log-sine table, filled at elaboration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module logsin_rom (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_en,
  input  fm_op_pkg::phase_stage_t in_stage,
  output fm_op_pkg::log_stage_t   out_stage
);
  import fm_op_pkg::*;

  // -log2(sin) in 1/log_steps units taken at the centre of each step
  function automatic logsin_t calc_logsin(input int a);
    real angle;
    real lg;
    angle = (real'(table_depth - 1 - a) + 0.5) * pi / real'(2 * table_depth);
    lg    = -$ln($sin(angle)) / $ln(2.0);
    return logsin_t'($rtoi(lg * log_steps + 0.5));
  endfunction

  logsin_t rom [table_depth];

  // Address 0 is the peak of the sine and needs no attenuation
  for (genvar i = 0; i < table_depth; i++) begin : g_rom
    localparam logsin_t entry = calc_logsin(i);
    assign rom[i] = entry;
  end

  log_stage_t looked_up;

  always_comb begin
    looked_up.logsin = rom[in_stage.addr];
    looked_up.sign   = in_stage.sign;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_stage <= '0;
    end else if (clk_en) begin
      out_stage <= looked_up;
    end
  end

endmodule

// File: source/op_atten.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Log-domain attenuation: sine plus scaled envelope, saturated
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module op_atten (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_en,
  input  fm_op_pkg::log_stage_t   in_stage,
  input  fm_op_pkg::env_t         env_atten,
  output fm_op_pkg::atten_stage_t out_stage
);
  import fm_op_pkg::*;

  atten_t             env_scaled;
  logic [atten_width:0] sum;
  atten_stage_t       summed;

  always_comb begin
    // Envelope steps are four times coarser than sine steps
    env_scaled = atten_t'(env_atten) << env_shift;
    // One extra bit catches the overflow
    sum = {1'b0, in_stage.logsin} + {1'b0, env_scaled};

    if (sum[atten_width]) begin
      summed.atten = atten_max;
    end else begin
      summed.atten = sum[atten_width-1:0];
    end
    summed.sign = in_stage.sign;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_stage <= '0;
    end else if (clk_en) begin
      out_stage <= summed;
    end
  end

endmodule

// File: source/op_exp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exponent stage: log attenuation back to a signed linear sample
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module op_exp (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_en,
  input  fm_op_pkg::atten_stage_t in_stage,
  output fm_op_pkg::sample_t      sample
);
  import fm_op_pkg::*;

  // Fractional power of two with full scale at k = 0
  function automatic mant_t calc_mant(input int k);
    real scale;
    real frac;
    scale = real'(1 << (mant_width - 1));
    frac  = $pow(2.0, -real'(k) / real'(log_steps));
    return mant_t'($rtoi(scale * frac + 0.5));
  endfunction

  mant_t exp_rom [table_depth];

  for (genvar k = 0; k < table_depth; k++) begin : g_exp
    localparam mant_t entry = calc_mant(k);
    assign exp_rom[k] = entry;
  end

  rom_addr_t                              frac_idx;
  logic [atten_width-addr_width-1:0]      shift;
  mant_t                                  mag;
  sample_t                                value;

  always_comb begin
    // Low byte selects the fraction and the high nibble the whole octaves
    frac_idx = in_stage.atten[addr_width-1:0];
    shift    = in_stage.atten[atten_width-1:addr_width];
    mag      = exp_rom[frac_idx] >> shift;
    if (in_stage.sign) begin
      value = -sample_t'({1'b0, mag});
    end else begin
      value = sample_t'({1'b0, mag});
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
    end else if (clk_en) begin
      sample <= value;
    end
  end

endmodule

// File: source/phase_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phase unit: phase accumulator and quadrant decode to table address and sign
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module phase_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clk_en,
  input  fm_op_pkg::phase_t       phase_inc,
  output fm_op_pkg::phase_stage_t stage
);
  import fm_op_pkg::*;

  phase_t                     acc;
  phase_t                     acc_next;
  logic [phase_top_width-1:0] top;
  phase_stage_t               decoded;

  // Decode from the updated phase so the stage lines up with the accumulator
  always_comb begin
    acc_next = acc + phase_inc;
    top      = acc_next[phase_width-1 -: phase_top_width];
    // Second half of the period is the negative half-wave
    decoded.sign = top[phase_top_width-1];
    // Rising quarter reads the table backwards, falling quarter forwards
    if (top[phase_top_width-2]) begin
      decoded.addr = top[addr_width-1:0];
    end else begin
      decoded.addr = ~top[addr_width-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      stage <= '0;
    end else if (clk_en) begin
      acc   <= acc_next;
      stage <= decoded;
    end
  end

endmodule

// File: tests/fm_operator_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM operator testbench: clock, reset, LFSR stimulus, reference model,
// checking assertions, timeout and the closing error count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fm_operator_tb;
  import fm_op_pkg::*;

  localparam int  reset_cycles    = 4;
  localparam int  sweep_cycles    = 3000;
  localparam int  random_cycles   = 2000;
  localparam int  max_env_cycles  = 400;
  localparam int  ramp_cycles     = 300;
  localparam int  drain_cycles    = 8;
  localparam int  stimulus_cycles = reset_cycles + sweep_cycles + random_cycles
                                    + max_env_cycles + ramp_cycles + drain_cycles + 1;
  localparam int  timeout_cycles  = 2 * stimulus_cycles;
  localparam int  env_max         = (1 << env_width) - 1;
  localparam real math_pi         = 3.14159265358979;

  // One model pipeline stage holding an address, log-sine, attenuation or sample
  typedef struct packed {
    logic   valid;
    logic   sign;
    phase_t acc;
    int     env;
    int     value;
  } model_stage_t;

  logic    clk;
  logic    rst;
  logic    clk_en;
  phase_t  phase_inc;
  env_t    env_atten;
  sample_t sample;

  logic [31:0]  lfsr = 32'hd07136ff;
  phase_t       m_acc;
  model_stage_t m1, m2, m3, m4, m_prev;
  int           strobes_since_rst;
  int           cycle_count = 0;
  int           model_errors = 0;
  int           hold_errors = 0;
  int           sign_errors = 0;
  int           env_errors = 0;

  fm_operator UUT (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .phase_inc (phase_inc),
    .env_atten (env_atten),
    .sample    (sample)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic int magnitude(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // Bit 9 of the top phase bits is the half-wave and bit 8 picks the mirror
  function automatic int ref_addr(input phase_t acc);
    int p;
    p = int'(acc) >> 10;
    return ((p & 256) != 0) ? (p & 255) : (255 - (p & 255));
  endfunction

  function automatic logic ref_sign(input phase_t acc);
    return ((int'(acc) >> 19) & 1) != 0;
  endfunction

  function automatic int ref_logsin(input int a);
    real angle;
    real octaves;
    angle   = (real'(255 - a) + 0.5) * math_pi / 512.0;
    octaves = -$ln($sin(angle)) / $ln(2.0);
    return $rtoi(octaves * 256.0 + 0.5);
  endfunction

  function automatic int ref_atten(input int logsin, input int env);
    int total;
    total = logsin + env * 4;
    return (total > 4095) ? 4095 : total;
  endfunction

  function automatic int ref_sample(input int atten, input logic sign);
    int mag;
    mag = $rtoi(1024.0 * $pow(2.0, -real'(atten % 256) / 256.0) + 0.5);
    mag = mag >> (atten / 256);
    return sign ? -mag : mag;
  endfunction

  // Reference pipeline with one stage per DUT register
  always @(posedge clk) begin : model_step
    phase_t       acc_new;
    model_stage_t n1, n2, n3, n4, np;
    acc_new  = m_acc + phase_inc;
    n1       = '{valid: 1'b1, sign: ref_sign(acc_new), acc: acc_new, env: 0,
                 value: ref_addr(acc_new)};
    n2       = m1;
    n2.value = ref_logsin(m1.value);
    n3       = m2;
    n3.env   = int'(env_atten);
    n3.value = ref_atten(m2.value, n3.env);
    n4       = m3;
    n4.value = ref_sample(m3.value, m3.sign);
    np       = m4;
    np.value = magnitude(m4.value);
    if (rst) begin
      m_acc             <= '0;
      m1                <= '0;
      m2                <= '0;
      m3                <= '0;
      m4                <= '0;
      m_prev            <= '0;
      strobes_since_rst <= 0;
    end else if (clk_en) begin
      m_acc  <= acc_new;
      m1     <= n1;
      m2     <= n2;
      m3     <= n3;
      m4     <= n4;
      m_prev <= np;
      if (strobes_since_rst < 3) begin
        strobes_since_rst <= strobes_since_rst + 1;
      end
    end
  end

  a_reset_zero: assert property (@(posedge clk) disable iff (rst)
    strobes_since_rst == 0 |-> sample == '0)
    else begin
      model_errors++;
      $display("FAIL %0t: sample %0d before the first strobe", $time, $sampled(sample));
    end

  a_model_match: assert property (@(posedge clk) disable iff (rst)
    int'(sample) == m4.value)
    else begin
      model_errors++;
      $display("FAIL %0t: sample %0d, expected %0d", $time, $sampled(sample),
               $sampled(m4.value));
    end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    !clk_en |=> $stable(sample))
    else begin
      hold_errors++;
      $display("FAIL %0t: sample changed while clk_en was low", $time);
    end

  a_sign_neg: assert property (@(posedge clk) disable iff (rst)
    m4.sign |-> int'(sample) <= 0)
    else begin
      sign_errors++;
      $display("FAIL %0t: sample %0d positive on negative half-wave", $time,
               $sampled(sample));
    end

  a_sign_pos: assert property (@(posedge clk) disable iff (rst)
    !m4.sign |-> int'(sample) >= 0)
    else begin
      sign_errors++;
      $display("FAIL %0t: sample %0d negative on positive half-wave", $time,
               $sampled(sample));
    end

  a_env_floor: assert property (@(posedge clk) disable iff (rst)
    m4.valid && m4.env == env_max |-> magnitude(int'(sample)) <= 1)
    else begin
      env_errors++;
      $display("FAIL %0t: sample %0d at full envelope attenuation", $time,
               $sampled(sample));
    end

  // More attenuation at the same phase never grows the magnitude
  a_env_monotonic: assert property (@(posedge clk) disable iff (rst)
    m4.valid && m_prev.valid && m4.acc == m_prev.acc && m4.env >= m_prev.env
    |-> magnitude(int'(sample)) <= m_prev.value)
    else begin
      env_errors++;
      $display("FAIL %0t: magnitude of %0d rose above %0d as envelope rose", $time,
               $sampled(sample), $sampled(m_prev.value));
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Three strobes in four on average
  task automatic random_strobe(output logic en);
    logic [31:0] bits;
    take_bits(2, bits);
    en = (bits[1:0] != 2'b00);
  endtask

  task automatic drive_cycle(input logic en, input phase_t inc, input env_t env);
    @(posedge clk);
    #1;
    clk_en    = en;
    phase_inc = inc;
    env_atten = env;
  endtask

  initial begin : stimulus
    logic        en;
    logic [31:0] inc_bits;
    logic [31:0] env_bits;
    int          env_level;
    int          table_errors;
    int          total;
    rst       = 1'b1;
    clk_en    = 1'b0;
    phase_inc = '0;
    env_atten = '0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;

    // Half-step increments visit every address for about two strobes each
    for (int i = 0; i < sweep_cycles; i++) begin
      random_strobe(en);
      drive_cycle(en, phase_t'(1 << 9), '0);
    end
    for (int i = 0; i < random_cycles; i++) begin
      random_strobe(en);
      take_bits(phase_width, inc_bits);
      take_bits(env_width, env_bits);
      drive_cycle(en, phase_t'(inc_bits[phase_width-1:0]), env_t'(env_bits[env_width-1:0]));
    end
    for (int i = 0; i < max_env_cycles; i++) begin
      random_strobe(en);
      take_bits(phase_width, inc_bits);
      drive_cycle(en, phase_t'(inc_bits[phase_width-1:0]), env_t'(env_max));
    end
    // Envelope ramps up to full attenuation while the phase stands still
    env_level = 0;
    for (int i = 0; i < ramp_cycles; i++) begin
      random_strobe(en);
      drive_cycle(en, '0, env_t'(env_level));
      env_level = (env_level + 4 > env_max) ? env_max : env_level + 4;
    end
    for (int i = 0; i < drain_cycles; i++) begin
      drive_cycle(1'b1, '0, env_t'(env_level));
    end

    @(posedge clk);
    #1;
    table_errors = UUT.u_logsin.u_props.error_count;
    total = model_errors + hold_errors + sign_errors + env_errors + table_errors;
    $display("Error counts: model %0d, hold %0d, sign %0d, envelope %0d, table %0d",
             model_errors, hold_errors, sign_errors, env_errors, table_errors);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tests/logsin_rom_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Log-sine table properties: hold, repeatability, monotonicity and anchors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module logsin_rom_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    clk_en,
  input fm_op_pkg::phase_stage_t in_stage,
  input fm_op_pkg::log_stage_t   out_stage
);
  import fm_op_pkg::*;

  localparam rom_addr_t peak_last  = 8'd7;
  localparam rom_addr_t mid_addr   = 8'd128;
  localparam rom_addr_t knee_addr  = 8'd170;
  localparam rom_addr_t floor_addr = 8'd255;

  // Address behind the current output and the output of the strobe before
  rom_addr_t out_addr;
  logic      out_valid;
  rom_addr_t prev_addr;
  logsin_t   prev_logsin;
  logic      prev_valid;
  // Failed table checks, summed by the testbench at the end of the run
  int        error_count = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_addr    <= '0;
      out_valid   <= 1'b0;
      prev_addr   <= '0;
      prev_logsin <= '0;
      prev_valid  <= 1'b0;
    end else if (clk_en) begin
      out_addr    <= in_stage.addr;
      out_valid   <= 1'b1;
      prev_addr   <= out_addr;
      prev_logsin <= out_stage.logsin;
      prev_valid  <= out_valid;
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    !clk_en |=> $stable(out_stage))
    else begin
      error_count++;
      $error("log-sine output changed without a clk_en strobe");
    end

  a_sign_forward: assert property (@(posedge clk) disable iff (rst)
    clk_en |=> out_stage.sign == $past(in_stage.sign))
    else begin
      error_count++;
      $error("half-wave sign was not forwarded with the table entry");
    end

  a_repeat: assert property (@(posedge clk) disable iff (rst)
    out_valid && prev_valid && out_addr == prev_addr |-> out_stage.logsin == prev_logsin)
    else begin
      error_count++;
      $error("same address gave different entries on consecutive strobes");
    end

  a_rising: assert property (@(posedge clk) disable iff (rst)
    out_valid && prev_valid && out_addr > prev_addr |-> out_stage.logsin >= prev_logsin)
    else begin
      error_count++;
      $error("table decreases toward higher addresses");
    end

  a_falling: assert property (@(posedge clk) disable iff (rst)
    out_valid && prev_valid && out_addr < prev_addr |-> out_stage.logsin <= prev_logsin)
    else begin
      error_count++;
      $error("table increases toward lower addresses");
    end

  // Anchors of the quarter wave
  a_anchor_peak: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_addr <= peak_last |-> out_stage.logsin == 12'h000)
    else begin
      error_count++;
      $error("peak entries are not zero");
    end

  a_anchor_mid: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_addr == mid_addr |-> out_stage.logsin == 12'h081)
    else begin
      error_count++;
      $error("entry at address 128 is not 0x081");
    end

  a_anchor_knee: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_addr == knee_addr |-> out_stage.logsin == 12'h0ff)
    else begin
      error_count++;
      $error("entry at address 170 is not 0x0ff");
    end

  a_anchor_floor: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_addr == floor_addr |-> out_stage.logsin == 12'h859)
    else begin
      error_count++;
      $error("entry at address 255 is not 0x859");
    end

endmodule

bind logsin_rom logsin_rom_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .clk_en    (clk_en),
  .in_stage  (in_stage),
  .out_stage (out_stage)
);
